// File: src/irq_pkg.sv
// Shared APB structs, register offsets, encoder result and claim FSM states for the IRQ controller
`default_nettype none

package irq_pkg;

    // APB port widths
    localparam int APB_AW = 4;
    localparam int APB_DW = 32;

    // word offsets of the register map
    localparam logic [APB_AW-1:0] ADDR_PENDING = 4'h0;
    localparam logic [APB_AW-1:0] ADDR_MASK    = 4'h4;
    localparam logic [APB_AW-1:0] ADDR_HOLDOFF = 4'h8;
    localparam logic [APB_AW-1:0] ADDR_CLAIM   = 4'hC;

    // widest source id, claim word holds it in the low bits
    localparam int MAX_ID_W = 5;

    // claim word valid flag position
    localparam int CLAIM_VLD_BIT = 31;

    typedef struct packed {
        logic              psel;
        logic              penable;
        logic              pwrite;
        logic [APB_AW-1:0] paddr;
        logic [APB_DW-1:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [APB_DW-1:0] prdata;
        logic              pready;
        logic              pslverr;
    } apb_rsp_t;

    // encoder output
    typedef struct packed {
        logic                valid;
        logic [MAX_ID_W-1:0] id;
    } prio_res_t;

    typedef enum logic [1:0] {
        IDLE,
        SETTLE,
        READY,
        HOLD
    } claim_state_e;

endpackage

`default_nettype wire

// File: src/irq_apb_regs.sv
// APB register block holding pending, mask and holdoff, feeding the encoder and the claim FSM
`timescale 1ns/1ps
`default_nettype none

module irq_apb_regs #(
    parameter int NUM_SRC = 16,
    parameter int HOLD_W  = 8
) (
    input  logic               clk,
    input  logic               rst_n,
    input  irq_pkg::apb_req_t  apb_req,
    output irq_pkg::apb_rsp_t  apb_rsp,
    input  logic [NUM_SRC-1:0] irq_src,
    input  irq_pkg::prio_res_t res,
    input  logic               claim_ok,
    output logic [NUM_SRC-1:0] eff,
    output logic               eff_chg,
    output logic               claim_rd,
    output logic [HOLD_W-1:0]  holdoff
);

    logic [NUM_SRC-1:0]         pending_q;
    logic [NUM_SRC-1:0]         pending_d;
    logic [NUM_SRC-1:0]         mask_q;
    logic [NUM_SRC-1:0]         mask_d;
    logic [NUM_SRC-1:0]         clr_vec;
    logic                       access;
    logic                       wr;
    logic                       rd;
    logic                       mapped;
    logic                       err;
    logic                       claim_hit;
    logic [irq_pkg::APB_DW-1:0] claim_word;
    logic [irq_pkg::APB_DW-1:0] rd_data;

    // access phase only, APB never waits
    assign access = apb_req.psel & apb_req.penable;
    assign wr     = access & apb_req.pwrite;
    assign rd     = access & ~apb_req.pwrite;

    always_comb begin
        case (apb_req.paddr)
            irq_pkg::ADDR_PENDING,
            irq_pkg::ADDR_MASK,
            irq_pkg::ADDR_HOLDOFF,
            irq_pkg::ADDR_CLAIM: mapped = 1'b1;
            default:             mapped = 1'b0;
        endcase
    end

    // unmapped offset, or a write to the read-only claim word
    assign err = access & (~mapped | (apb_req.pwrite & (apb_req.paddr == irq_pkg::ADDR_CLAIM)));

    assign claim_rd  = rd & (apb_req.paddr == irq_pkg::ADDR_CLAIM);
    assign claim_hit = claim_rd & claim_ok & res.valid;

    always_comb begin
        claim_word = '0;
        if (claim_ok && res.valid) begin
            claim_word[irq_pkg::CLAIM_VLD_BIT]  = 1'b1;
            claim_word[irq_pkg::MAX_ID_W-1:0] = res.id;
        end
    end

    // w1c from software plus the claimed bit
    always_comb begin
        clr_vec = '0;
        if (wr && (apb_req.paddr == irq_pkg::ADDR_PENDING)) begin
            clr_vec = apb_req.pwdata[NUM_SRC-1:0];
        end
        if (claim_hit) begin
            clr_vec = clr_vec | (NUM_SRC'(1) << res.id);
        end
    end

    // a source still asserted keeps its bit set
    assign pending_d = (pending_q & ~clr_vec) | irq_src;
    assign mask_d    = (wr && (apb_req.paddr == irq_pkg::ADDR_MASK)) ?
                       apb_req.pwdata[NUM_SRC-1:0] : mask_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pending_q <= '0;
            mask_q    <= '0;
            holdoff   <= '0;
        end else begin
            pending_q <= pending_d;
            mask_q    <= mask_d;
            if (wr && (apb_req.paddr == irq_pkg::ADDR_HOLDOFF)) begin
                holdoff <= apb_req.pwdata[HOLD_W-1:0];
            end
        end
    end

    assign eff     = pending_q & mask_q;
    assign eff_chg = (pending_d & mask_d) != eff;

    always_comb begin
        rd_data = '0;
        if (rd && !err) begin
            case (apb_req.paddr)
                irq_pkg::ADDR_PENDING: rd_data[NUM_SRC-1:0] = pending_q;
                irq_pkg::ADDR_MASK:    rd_data[NUM_SRC-1:0] = mask_q;
                irq_pkg::ADDR_HOLDOFF: rd_data[HOLD_W-1:0]  = holdoff;
                irq_pkg::ADDR_CLAIM:   rd_data              = claim_word;
                default:               rd_data              = '0;
            endcase
        end
    end

    assign apb_rsp = '{prdata: rd_data, pready: 1'b1, pslverr: err};

endmodule

`default_nettype wire

// File: src/seg_prio_enc.sv
// Two-stage segmented priority encoder returning the lowest set index of the masked pending vector
`timescale 1ns/1ps
`default_nettype none

module seg_prio_enc #(
    parameter int NUM_SRC  = 16,
    parameter int SEGMENTS = 4
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic [NUM_SRC-1:0] eff,
    output irq_pkg::prio_res_t res
);

    localparam int SEG_W = NUM_SRC / SEGMENTS;
    localparam int LOC_W = (SEG_W > 1) ? $clog2(SEG_W) : 1;
    localparam int ID_W  = irq_pkg::MAX_ID_W;

    logic [SEGMENTS-1:0]            seg_vld_d;
    logic [SEGMENTS-1:0]            seg_vld_q;
    logic [SEGMENTS-1:0][LOC_W-1:0] seg_loc_d;
    logic [SEGMENTS-1:0][LOC_W-1:0] seg_loc_q;
    irq_pkg::prio_res_t             res_d;

    // stage one, per segment
    // scan downward so the lowest set bit is the last to write
    always_comb begin
        seg_vld_d = '0;
        seg_loc_d = '0;
        for (int s = 0; s < SEGMENTS; s++) begin
            for (int i = SEG_W - 1; i >= 0; i--) begin
                if (eff[s*SEG_W + i]) begin
                    seg_vld_d[s] = 1'b1;
                    seg_loc_d[s] = LOC_W'(i);
                end
            end
        end
    end

    // stage two, lowest valid segment wins
    always_comb begin
        res_d = '0;
        for (int s = SEGMENTS - 1; s >= 0; s--) begin
            if (seg_vld_q[s]) begin
                res_d.valid = 1'b1;
                res_d.id    = ID_W'(s * SEG_W + int'(seg_loc_q[s]));
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            seg_vld_q <= '0;
            seg_loc_q <= '0;
            res       <= '0;
        end else begin
            seg_vld_q <= seg_vld_d;
            seg_loc_q <= seg_loc_d;
            res       <= res_d;
        end
    end

endmodule

`default_nettype wire

// File: src/irq_holdoff_timer.sv
// Down-counter timing the encoder settle window and the post-claim holdoff
`timescale 1ns/1ps
`default_nettype none

module irq_holdoff_timer #(
    parameter int HOLD_W = 8
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              start,
    input  logic [HOLD_W-1:0] len,
    output logic              done
);

    // one extra bit for len plus 2
    localparam int CNT_W = HOLD_W + 1;

    logic [CNT_W-1:0] cnt_q;

    // the extra 2 cycles cover the encoder pipeline
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt_q <= '0;
        end else if (start) begin
            cnt_q <= CNT_W'(len) + CNT_W'(2);
        end else if (cnt_q != '0) begin
            cnt_q <= cnt_q - CNT_W'(1);
        end
    end

    // high in the cycle whose edge takes the count to zero
    assign done = (cnt_q == CNT_W'(1));

endmodule

`default_nettype wire

// File: src/irq_claim_fsm.sv
// Claim state machine gating irq until the encoder settles and honoring claims only in READY
`timescale 1ns/1ps
`default_nettype none

module irq_claim_fsm #(
    parameter int HOLD_W = 8
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               eff_chg,
    input  logic               claim_rd,
    input  irq_pkg::prio_res_t res,
    input  logic [HOLD_W-1:0]  holdoff,
    input  logic               done,
    output logic               start,
    output logic [HOLD_W-1:0]  len,
    output logic               claim_ok,
    output logic               irq
);

    irq_pkg::claim_state_e state_q;
    irq_pkg::claim_state_e state_d;
    logic                  take;

    assign claim_ok = (state_q == irq_pkg::READY);
    assign irq      = claim_ok & res.valid;
    assign take     = claim_ok & claim_rd;

    always_comb begin
        state_d = state_q;
        start   = 1'b0;
        len     = '0;
        case (state_q)
            irq_pkg::IDLE: begin
                if (eff_chg) begin
                    state_d = irq_pkg::SETTLE;
                    start   = 1'b1;
                end
            end
            irq_pkg::SETTLE: begin
                // another change restarts the settle window
                if (eff_chg) begin
                    start = 1'b1;
                end else if (done) begin
                    state_d = irq_pkg::READY;
                end
            end
            irq_pkg::READY: begin
                if (take) begin
                    state_d = irq_pkg::HOLD;
                    start   = 1'b1;
                    len     = holdoff;
                end else if (eff_chg) begin
                    state_d = irq_pkg::SETTLE;
                    start   = 1'b1;
                end
            end
            irq_pkg::HOLD: begin
                // eff changes here ride out the holdoff
                if (done) begin
                    state_d = irq_pkg::READY;
                end
            end
            default: state_d = irq_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= irq_pkg::IDLE;
        end else begin
            state_q <= state_d;
        end
    end

endmodule

`default_nettype wire

// File: src/irq_ctrl_top.sv
// IRQ controller top level that sets the parameters and wires regs, encoder, FSM and timer
`timescale 1ns/1ps
`default_nettype none

module irq_ctrl_top #(
    parameter int NUM_SRC  = 16,
    parameter int SEGMENTS = 4,
    parameter int HOLD_W   = 8
) (
    input  logic               clk,
    input  logic               rst_n,
    input  irq_pkg::apb_req_t  apb_req,
    output irq_pkg::apb_rsp_t  apb_rsp,
    input  logic [NUM_SRC-1:0] irq_src,
    output logic               irq
);

    logic [NUM_SRC-1:0] eff;
    logic               eff_chg;
    logic               claim_rd;
    logic               claim_ok;
    logic [HOLD_W-1:0]  holdoff;
    logic [HOLD_W-1:0]  len;
    logic               start;
    logic               done;
    irq_pkg::prio_res_t res;

    irq_apb_regs #(
        .NUM_SRC (NUM_SRC),
        .HOLD_W  (HOLD_W)
    ) i_regs (
        .clk      (clk),
        .rst_n    (rst_n),
        .apb_req  (apb_req),
        .apb_rsp  (apb_rsp),
        .irq_src  (irq_src),
        .res      (res),
        .claim_ok (claim_ok),
        .eff      (eff),
        .eff_chg  (eff_chg),
        .claim_rd (claim_rd),
        .holdoff  (holdoff)
    );

    seg_prio_enc #(
        .NUM_SRC  (NUM_SRC),
        .SEGMENTS (SEGMENTS)
    ) i_enc (
        .clk   (clk),
        .rst_n (rst_n),
        .eff   (eff),
        .res   (res)
    );

    irq_claim_fsm #(
        .HOLD_W (HOLD_W)
    ) i_fsm (
        .clk      (clk),
        .rst_n    (rst_n),
        .eff_chg  (eff_chg),
        .claim_rd (claim_rd),
        .res      (res),
        .holdoff  (holdoff),
        .done     (done),
        .start    (start),
        .len      (len),
        .claim_ok (claim_ok),
        .irq      (irq)
    );

    irq_holdoff_timer #(
        .HOLD_W (HOLD_W)
    ) i_timer (
        .clk   (clk),
        .rst_n (rst_n),
        .start (start),
        .len   (len),
        .done  (done)
    );

endmodule

`default_nettype wire

// File: bench/tb_irq_ctrl.sv
// Self-checking testbench that drives the IRQ controller over APB and checks every claim
`timescale 1ns/1ps
`default_nettype none

module tb_irq_ctrl;

    localparam int NUM_SRC    = 16;
    localparam int CLK_PERIOD = 20;
    // several times the cycles the test sequence needs
    localparam int MAX_CYCLES = 4000;

    logic               clk;
    logic               rst_n;
    irq_pkg::apb_req_t  apb_req;
    irq_pkg::apb_rsp_t  apb_rsp;
    logic [NUM_SRC-1:0] irq_src;
    logic               irq;

    logic [31:0]        lcg_state;
    logic [NUM_SRC-1:0] pend_model;
    logic [NUM_SRC-1:0] mask_model;
    int                 cycle_cnt = 0;

    irq_ctrl_top #(
        .NUM_SRC  (NUM_SRC),
        .SEGMENTS (4)
    ) i_dut (
        .clk     (clk),
        .rst_n   (rst_n),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp),
        .irq_src (irq_src),
        .irq     (irq)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD/2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("TEST FAILED");
            $display("timeout: the run went past %0d clock cycles", MAX_CYCLES);
            $fatal(1);
        end
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic rand16(output logic [15:0] v);
        lcg_state = lcg_next(lcg_state);
        v = lcg_state[31:16];
    endtask

    // lowest set index of pending and mask as {valid, id}
    function automatic logic [5:0] expect_claim(input logic [NUM_SRC-1:0] pend,
                                                input logic [NUM_SRC-1:0] mask);
        logic [NUM_SRC-1:0] v;
        v = pend & mask;
        for (int i = 0; i < NUM_SRC; i++) begin
            if (v[i]) begin
                return {1'b1, 5'(i)};
            end
        end
        return 6'b0;
    endfunction

    // claim word with valid in bit 31 and id in the low bits
    function automatic logic [31:0] claim_word(input logic [5:0] e);
        logic [31:0] w;
        w = '0;
        if (e[5]) begin
            w[31]  = 1'b1;
            w[4:0] = e[4:0];
        end
        return w;
    endfunction

    // only the three read/write registers accept a write
    function automatic logic write_err(input logic [3:0] addr);
        return !(addr == irq_pkg::ADDR_PENDING || addr == irq_pkg::ADDR_MASK ||
                 addr == irq_pkg::ADDR_HOLDOFF);
    endfunction

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            $display("TEST FAILED");
            $display("CHECK FAILED %s: expected 0x%08h, actual 0x%08h", name, exp, act);
            $fatal(1);
        end
    endtask

    task automatic apb_write(input logic [3:0] addr, input logic [31:0] data);
        @(negedge clk);
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = 1'b1;
        apb_req.paddr   = addr;
        apb_req.pwdata  = data;
        @(negedge clk);
        apb_req.penable = 1'b1;
        #(CLK_PERIOD/4);
        check("write pready", 32'd1, apb_rsp.pready);
        check("write pslverr", write_err(addr), apb_rsp.pslverr);
        @(negedge clk);
        apb_req.psel    = 1'b0;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = 1'b0;
    endtask

    task automatic apb_read(input logic [3:0] addr, output logic [31:0] data, output logic err);
        @(negedge clk);
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = 1'b0;
        apb_req.paddr   = addr;
        @(negedge clk);
        apb_req.penable = 1'b1;
        // sample well before the rising edge of the access cycle
        #(CLK_PERIOD/4);
        data = apb_rsp.prdata;
        err  = apb_rsp.pslverr;
        check("pready", 32'd1, apb_rsp.pready);
        @(negedge clk);
        apb_req.psel    = 1'b0;
        apb_req.penable = 1'b0;
    endtask

    task automatic read_expect(input string name, input logic [3:0] addr, input logic [31:0] exp);
        logic [31:0] data;
        logic        err;
        apb_read(addr, data, err);
        check(name, exp, data);
        check({name, " pslverr"}, 32'd0, err);
    endtask

    task automatic claim_next(input string name);
        logic [31:0] data;
        logic        err;
        logic [5:0]  e;
        e = expect_claim(pend_model, mask_model);
        apb_read(irq_pkg::ADDR_CLAIM, data, err);
        check(name, claim_word(e), data);
        check({name, " pslverr"}, 32'd0, err);
        if (e[5]) begin
            pend_model[e[4:0]] = 1'b0;
        end
    endtask

    task automatic write_mask(input logic [NUM_SRC-1:0] m);
        apb_write(irq_pkg::ADDR_MASK, 32'(m));
        mask_model = m;
    endtask

    task automatic clear_pending(input logic [NUM_SRC-1:0] v);
        apb_write(irq_pkg::ADDR_PENDING, 32'(v));
        pend_model = pend_model & ~v;
    endtask

    // one-cycle pulse on the sources that the sticky pending bits catch
    task automatic pulse_src(input logic [NUM_SRC-1:0] pat);
        @(negedge clk);
        irq_src = pat;
        @(negedge clk);
        irq_src = '0;
        pend_model = pend_model | pat;
    endtask

    task automatic wait_irq(input string name, input int limit);
        int n;
        n = 0;
        while (irq !== 1'b1 && n < limit) begin
            @(negedge clk);
            n++;
        end
        check(name, 32'd1, irq);
    endtask

    task automatic expect_irq_low(input string name, input int cycles);
        check(name, 32'd0, irq);
        repeat (cycles) begin
            @(negedge clk);
            check(name, 32'd0, irq);
        end
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) @(negedge clk);
    endtask

    initial begin
        logic [31:0] data;
        logic        err;
        logic [15:0] r0;
        logic [15:0] r1;
        logic [5:0]  e;

        rst_n      = 1'b0;
        apb_req    = '0;
        irq_src    = '0;
        lcg_state  = 32'h7fd83997;
        pend_model = '0;
        mask_model = '0;
        repeat (2) @(negedge clk);
        rst_n = 1'b1;

        // reset values
        check("reset irq", 32'd0, irq);
        read_expect("reset pending", irq_pkg::ADDR_PENDING, 32'd0);
        read_expect("reset mask", irq_pkg::ADDR_MASK, 32'd0);
        read_expect("reset holdoff", irq_pkg::ADDR_HOLDOFF, 32'd0);
        read_expect("reset claim", irq_pkg::ADDR_CLAIM, 32'd0);
        apb_read(4'h2, data, err);
        check("unmapped data", 32'd0, data);
        check("unmapped pslverr", 32'd1, err);

        // writes to the claim word and to a hole are rejected
        apb_write(irq_pkg::ADDR_CLAIM, 32'hffff_ffff);
        apb_write(4'h6, 32'hffff_ffff);
        read_expect("mask after rejected writes", irq_pkg::ADDR_MASK, 32'd0);

        // register access and w1c
        write_mask(16'ha5c3);
        read_expect("mask readback", irq_pkg::ADDR_MASK, 32'h0000a5c3);
        apb_write(irq_pkg::ADDR_HOLDOFF, 32'h37);
        read_expect("holdoff readback", irq_pkg::ADDR_HOLDOFF, 32'h37);
        apb_write(irq_pkg::ADDR_HOLDOFF, 32'd0);
        pulse_src(16'h1234);
        read_expect("pending after pulse", irq_pkg::ADDR_PENDING, 32'(pend_model));
        clear_pending(16'h0204);
        read_expect("pending after w1c", irq_pkg::ADDR_PENDING, 32'(pend_model));

        // random pending and mask with one claim each
        for (int t = 0; t < 24; t++) begin
            rand16(r0);
            rand16(r1);
            write_mask(r1);
            clear_pending(16'hffff);
            pulse_src(r0);
            e = expect_claim(pend_model, mask_model);
            if (e[5]) begin
                wait_irq("random irq", 3);
                claim_next("random claim");
                read_expect("random pending", irq_pkg::ADDR_PENDING, 32'(pend_model));
            end else begin
                idle_cycles(3);
                check("random no irq", 32'd0, irq);
                read_expect("random empty claim", irq_pkg::ADDR_CLAIM, 32'd0);
            end
        end

        // drain in ascending id order
        for (int round = 0; round < 3; round++) begin
            rand16(r0);
            rand16(r1);
            write_mask(r1 | 16'h0101);
            clear_pending(16'hffff);
            pulse_src(r0 | 16'h0300);
            e = expect_claim(pend_model, mask_model);
            while (e[5]) begin
                wait_irq("drain irq", 4);
                claim_next("drain claim");
                e = expect_claim(pend_model, mask_model);
            end
            expect_irq_low("drain irq low", 4);
            read_expect("drain final claim", irq_pkg::ADDR_CLAIM, 32'd0);
        end

        // holdoff window of H+2 cycles
        apb_write(irq_pkg::ADDR_HOLDOFF, 32'd5);
        write_mask(16'hffff);
        clear_pending(16'hffff);
        pulse_src(16'h0a44);
        wait_irq("holdoff irq", 3);
        claim_next("holdoff claim");
        expect_irq_low("holdoff window", 6);
        @(negedge clk);
        check("holdoff release", 32'd1, irq);

        // claim inside the window is refused
        apb_write(irq_pkg::ADDR_HOLDOFF, 32'd12);
        wait_irq("long holdoff irq", 3);
        claim_next("long holdoff claim");
        read_expect("claim inside holdoff", irq_pkg::ADDR_CLAIM, 32'd0);
        read_expect("pending after refused claim", irq_pkg::ADDR_PENDING, 32'(pend_model));
        check("irq inside holdoff", 32'd0, irq);
        wait_irq("irq after long holdoff", 16);
        claim_next("claim after long holdoff");
        apb_write(irq_pkg::ADDR_HOLDOFF, 32'd0);
        idle_cycles(16);

        // mask hides a source and unmask restores its priority
        clear_pending(16'hffff);
        pulse_src(16'h0224);
        wait_irq("mask irq", 3);
        write_mask(16'hfffb);
        wait_irq("masked irq", 4);
        claim_next("masked claim");
        write_mask(16'hffff);
        wait_irq("unmasked irq", 4);
        claim_next("unmasked claim");
        wait_irq("last irq", 4);
        claim_next("last claim");
        expect_irq_low("mask test irq low", 4);
        read_expect("mask test pending", irq_pkg::ADDR_PENDING, 32'd0);

        $display("TEST PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: tb.f
src/irq_pkg.sv
src/irq_apb_regs.sv
src/seg_prio_enc.sv
src/irq_holdoff_timer.sv
src/irq_claim_fsm.sv
src/irq_ctrl_top.sv
bench/tb_irq_ctrl.sv

// File: Bender.yml
package:
  name: irq_ctrl

sources:
  - src/irq_pkg.sv
  - src/irq_apb_regs.sv
  - src/seg_prio_enc.sv
  - src/irq_holdoff_timer.sv
  - src/irq_claim_fsm.sv
  - src/irq_ctrl_top.sv
  - target: test
    files:
      - bench/tb_irq_ctrl.sv
